//--- logic/bpu_consts.svh
// ----------------------------------------------------------------------
// branch predictor sizes, table index widths and the 2-bit counter
// encodings shared by the bht, btb and resolve logic
// ----------------------------------------------------------------------
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

`define BPU_PC_W        32          // pc width

`define BPU_BHT_ENTRIES 256         // counters, indexed by pc[9:2]
`define BPU_BHT_IDX_W   8

`define BPU_BTB_ENTRIES 64          // targets, indexed by pc[7:2]
`define BPU_BTB_IDX_W   6
`define BPU_BTB_TAG_W   24          // pc[31:8]

`define BPU_CNT_SN      2'b00       // strongly not taken
`define BPU_CNT_WN      2'b01       // weakly not taken
`define BPU_CNT_WT      2'b10       // weakly taken
`define BPU_CNT_ST      2'b11       // strongly taken

`endif

//--- logic/bpu_pkg.sv
// ----------------------------------------------------------------------
// packed structs passed between fetch, the prediction tables and the
// branch resolve handshake
// ----------------------------------------------------------------------
`default_nettype none

`include "bpu_consts.svh"

package bpu_pkg;

    typedef struct packed {
        logic                   valid;
        logic [`BPU_PC_W-1:0]   pc;             // fetch address
    } fetch_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   taken;
        logic                   btb_hit;
        logic [`BPU_PC_W-1:0]   next_pc;        // btb target or pc+4
    } prediction_t;

    // pred_taken and pred_next_pc echo what fetch was given earlier
    typedef struct packed {
        logic [`BPU_PC_W-1:0]   pc;
        logic                   taken;          // actual outcome
        logic [`BPU_PC_W-1:0]   target;
        logic                   pred_taken;
        logic [`BPU_PC_W-1:0]   pred_next_pc;
    } resolve_t;

    typedef struct packed {
        logic                   mispredict;
        logic [`BPU_PC_W-1:0]   correct_pc;
    } redirect_t;

    typedef struct packed {
        logic                   en;             // one-cycle write strobe
        logic [`BPU_PC_W-1:0]   pc;
        logic                   taken;
        logic [`BPU_PC_W-1:0]   target;
    } table_upd_t;

endpackage

`default_nettype wire

//--- logic/bht.sv
// ----------------------------------------------------------------------
// branch history table: 2-bit saturating counters with per-entry valid
// bits, one combinational read port and one clocked update port
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "bpu_consts.svh"

module bht (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`BPU_PC_W-1:0]   rd_pc,
    output logic [1:0]                  rd_cnt,
    input  wire bpu_pkg::table_upd_t    upd
);

    logic [`BPU_BHT_IDX_W-1:0]      rd_idx;
    logic [`BPU_BHT_IDX_W-1:0]      wr_idx;
    logic [1:0]                     cnt_mem [`BPU_BHT_ENTRIES];
    logic [`BPU_BHT_ENTRIES-1:0]    entry_valid;
    logic [1:0]                     old_cnt;
    logic [1:0]                     new_cnt;

    // word aligned pcs, so bits 1:0 carry no information
    assign rd_idx = rd_pc[`BPU_BHT_IDX_W+1:2];
    assign wr_idx = upd.pc[`BPU_BHT_IDX_W+1:2];

    // never-written entries look strongly not taken
    assign rd_cnt = entry_valid[rd_idx] ? cnt_mem[rd_idx] : `BPU_CNT_SN;

    // counter as it stands before this update
    assign old_cnt = entry_valid[wr_idx] ? cnt_mem[wr_idx] : `BPU_CNT_SN;

    // saturating step toward the resolved direction
    always_comb begin
        case (old_cnt)
            `BPU_CNT_SN: begin
                new_cnt = upd.taken ? `BPU_CNT_WN : `BPU_CNT_SN;   // floor
            end
            `BPU_CNT_WN: begin
                new_cnt = upd.taken ? `BPU_CNT_WT : `BPU_CNT_SN;
            end
            `BPU_CNT_WT: begin
                new_cnt = upd.taken ? `BPU_CNT_ST : `BPU_CNT_WN;
            end
            default: begin
                new_cnt = upd.taken ? `BPU_CNT_ST : `BPU_CNT_WT;   // ceiling
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;              // table starts empty
        end else if (upd.en) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // counter storage, qualified by entry_valid on every read
    always_ff @(posedge clk) begin
        if (upd.en) begin
            cnt_mem[wr_idx] <= new_cnt;
        end
    end

    // an X pc would corrupt an unknown set of counters
    a_upd_pc_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        upd.en |-> !$isunknown(upd.pc)
    ) else $error("bht update with unknown pc %h", upd.pc);

endmodule

`default_nettype wire

//--- logic/btb.sv
// ----------------------------------------------------------------------
// direct-mapped branch target buffer with 24-bit tags, combinational
// lookup and allocation on taken branch resolution
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "bpu_consts.svh"

module btb (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`BPU_PC_W-1:0]   rd_pc,
    output logic                        hit,
    output logic [`BPU_PC_W-1:0]        target,
    input  wire bpu_pkg::table_upd_t    upd
);

    logic [`BPU_BTB_IDX_W-1:0]      rd_idx;
    logic [`BPU_BTB_IDX_W-1:0]      wr_idx;
    logic [`BPU_BTB_TAG_W-1:0]      rd_tag;
    logic [`BPU_BTB_TAG_W-1:0]      wr_tag;
    logic [`BPU_BTB_TAG_W-1:0]      tag_mem [`BPU_BTB_ENTRIES];
    logic [`BPU_PC_W-3:0]           tgt_mem [`BPU_BTB_ENTRIES];    // word address only
    logic [`BPU_BTB_ENTRIES-1:0]    entry_valid;
    logic                           alloc;

    // index pc[7:2], tag pc[31:8]
    assign rd_idx = rd_pc[`BPU_BTB_IDX_W+1:2];
    assign wr_idx = upd.pc[`BPU_BTB_IDX_W+1:2];
    assign rd_tag = rd_pc[`BPU_PC_W-1 -: `BPU_BTB_TAG_W];
    assign wr_tag = upd.pc[`BPU_PC_W-1 -: `BPU_BTB_TAG_W];

    // not-taken resolves leave the entry alone
    assign alloc = upd.en & upd.taken;

    assign hit    = entry_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target = {tgt_mem[rd_idx], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (alloc) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // a new tag simply evicts whatever aliased there before
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[wr_idx] <= wr_tag;
            tgt_mem[wr_idx] <= upd.target[`BPU_PC_W-1:2];
        end
    end

    // low target bits are dropped on write and rebuilt as zero
    a_target_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc |-> (upd.target[1:0] == 2'b00)
    ) else $error("btb write of unaligned target %h", upd.target);

endmodule

`default_nettype wire

//--- logic/branch_resolve.sv
// ----------------------------------------------------------------------
// responder for the four-phase resolve handshake, one-cycle table write
// strobe, misprediction check and redirect pc
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "bpu_consts.svh"

module branch_resolve (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   resolve_req,
    input  wire bpu_pkg::resolve_t      resolve,
    output logic                        resolve_ack,
    output bpu_pkg::redirect_t          redirect,
    output bpu_pkg::table_upd_t         upd
);

    logic                   start;
    logic                   ack_q;
    logic                   mispredict_d;
    logic                   mispredict_q;
    logic [`BPU_PC_W-1:0]   correct_pc_d;
    logic [`BPU_PC_W-1:0]   correct_pc_q;

    // high only in the cycle before ack rises
    assign start = resolve_req & ~ack_q;

    // wrong direction, or right direction with a stale target
    assign mispredict_d = (resolve.taken != resolve.pred_taken) ||
                          (resolve.taken && (resolve.target != resolve.pred_next_pc));
    assign correct_pc_d = resolve.taken ? resolve.target : resolve.pc + 4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q        <= 1'b0;
            mispredict_q <= 1'b0;
        end else if (start) begin
            ack_q        <= 1'b1;
            mispredict_q <= mispredict_d;
        end else if (!resolve_req) begin
            ack_q        <= 1'b0;   // return to idle once req drops
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            correct_pc_q <= correct_pc_d;
        end
    end

    assign resolve_ack = ack_q;
    assign redirect    = '{mispredict: mispredict_q, correct_pc: correct_pc_q};
    assign upd         = '{en: start, pc: resolve.pc, taken: resolve.taken,
                           target: resolve.target};

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(resolve_ack) |-> $past(resolve_req)
    ) else $error("resolve_ack rose without resolve_req");

    // requester must hold the branch fields for the whole req phase
    a_resolve_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (resolve_req && $past(resolve_req)) |-> $stable(resolve)
    ) else $error("resolve changed while resolve_req was high");

endmodule

`default_nettype wire

//--- logic/bpu_top.sv
// ----------------------------------------------------------------------
// branch prediction unit top: table lookup, prediction rule and
// prediction register, plus the resolve path into both tables
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "bpu_consts.svh"

module bpu_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire bpu_pkg::fetch_req_t    fetch,
    output bpu_pkg::prediction_t        prediction,
    input  wire logic                   resolve_req,
    input  wire bpu_pkg::resolve_t      resolve,
    output logic                        resolve_ack,
    output bpu_pkg::redirect_t          redirect
);

    bpu_pkg::table_upd_t    upd;
    logic [1:0]             cnt;
    logic                   btb_hit;
    logic [`BPU_PC_W-1:0]   btb_target;
    logic                   pred_taken;
    logic [`BPU_PC_W-1:0]   pred_next_pc;
    logic                   valid_q;
    logic                   taken_q;
    logic                   hit_q;
    logic [`BPU_PC_W-1:0]   next_pc_q;

    bht i_bht (.clk, .rst_n, .rd_pc(fetch.pc), .rd_cnt(cnt), .upd);

    btb i_btb (.clk, .rst_n, .rd_pc(fetch.pc), .hit(btb_hit), .target(btb_target), .upd);

    branch_resolve i_resolve (.clk, .rst_n, .resolve_req, .resolve, .resolve_ack,
                              .redirect, .upd);

    // taken needs both a taken counter and a known target
    assign pred_taken   = cnt[1] & btb_hit;
    assign pred_next_pc = pred_taken ? btb_target : fetch.pc + 4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch.valid;     // one cycle lookup latency
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.valid) begin
            taken_q   <= pred_taken;
            hit_q     <= btb_hit;
            next_pc_q <= pred_next_pc;
        end
    end

    assign prediction = '{valid: valid_q, taken: taken_q, btb_hit: hit_q, next_pc: next_pc_q};

endmodule

`default_nettype wire

//--- sim/bpu_checker.sv
// ----------------------------------------------------------------------
// bpu checker: compares prediction one cycle after each lookup and
// redirect when resolve_ack rises with the expected vector values
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "bpu_consts.svh"

module bpu_checker (
    input  wire logic                   clk,
    input  wire bpu_pkg::prediction_t   prediction,
    input  wire logic                   resolve_ack,
    input  wire bpu_pkg::redirect_t     redirect
);

    localparam int ACK_LIMIT = 20;          // cycles from req to ack

    int                     test_count = 0;
    int                     error_count = 0;

    // requests bump a sequence number, the clock edges below follow it
    int                     lk_req_seq = 0;
    int                     lk_taken_seq = 0;
    int                     lk_done_seq = 0;
    string                  lk_req_name;
    string                  lk_name;
    logic [`BPU_PC_W+1:0]   lk_req_exp;     // {taken, btb_hit, next_pc}
    logic [`BPU_PC_W+1:0]   lk_exp;

    int                     rs_req_seq = 0;
    int                     rs_taken_seq = 0;
    int                     rs_done_seq = 0;
    int                     rs_wait = 0;
    string                  rs_req_name;
    string                  rs_name;
    logic [`BPU_PC_W:0]     rs_req_exp;     // {mispredict, correct_pc}
    logic [`BPU_PC_W:0]     rs_exp;

    task automatic expect_lookup(input string name, input logic taken, input logic hit,
                                 input logic [`BPU_PC_W-1:0] next_pc);
        lk_req_name = name;
        lk_req_exp  = {taken, hit, next_pc};
        lk_req_seq++;
    endtask

    task automatic expect_resolve(input string name, input logic mispredict,
                                  input logic [`BPU_PC_W-1:0] correct_pc);
        rs_req_name = name;
        rs_req_exp  = {mispredict, correct_pc};
        rs_req_seq++;
    endtask

    // expectations become current on the edge where the dut sees the request
    always @(posedge clk) begin
        if (lk_req_seq != lk_taken_seq) begin
            lk_name      = lk_req_name;
            lk_exp       = lk_req_exp;
            lk_taken_seq = lk_req_seq;
        end
        if (rs_req_seq != rs_taken_seq) begin
            rs_name      = rs_req_name;
            rs_exp       = rs_req_exp;
            rs_taken_seq = rs_req_seq;
        end
    end

    // outputs are compared half a cycle after the edge that produced them
    always @(negedge clk) begin
        if (lk_taken_seq != lk_done_seq) begin
            lk_done_seq = lk_taken_seq;
            test_count++;
            if (!prediction.valid) begin
                error_count++;
                $display("%s: prediction not valid one cycle after the lookup", lk_name);
            end else if ({prediction.taken, prediction.btb_hit, prediction.next_pc}
                         != lk_exp) begin
                error_count++;
                $display("ERR %s: expected taken=%0b hit=%0b next_pc=%h, %s",
                         lk_name, lk_exp[`BPU_PC_W+1], lk_exp[`BPU_PC_W],
                         lk_exp[`BPU_PC_W-1:0],
                         $sformatf("actual taken=%0b hit=%0b next_pc=%h",
                                   prediction.taken, prediction.btb_hit,
                                   prediction.next_pc));
            end else begin
                $display("ok  %s", lk_name);
            end
        end
        if (rs_taken_seq != rs_done_seq) begin
            if (resolve_ack) begin                      // first sample with ack high
                rs_done_seq = rs_taken_seq;
                rs_wait     = 0;
                test_count++;
                if ({redirect.mispredict, redirect.correct_pc} != rs_exp) begin
                    error_count++;
                    $display("ERR %s: expected mispredict=%0b correct_pc=%h, %s",
                             rs_name, rs_exp[`BPU_PC_W], rs_exp[`BPU_PC_W-1:0],
                             $sformatf("actual mispredict=%0b correct_pc=%h",
                                       redirect.mispredict, redirect.correct_pc));
                end else begin
                    $display("ok  %s", rs_name);
                end
            end else if (rs_wait == ACK_LIMIT - 1) begin
                rs_done_seq = rs_taken_seq;
                rs_wait     = 0;
                test_count++;
                error_count++;
                $display("%s: resolve_ack did not rise within %0d cycles of resolve_req",
                         rs_name, ACK_LIMIT);
            end else begin
                rs_wait++;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/bpu_tb.sv
// ----------------------------------------------------------------------
// bpu testbench: clock, reset, vector file reading, lookup and resolve
// stimulus on the falling edge, cycle timeout and final report
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

`include "bpu_consts.svh"

module bpu_tb;

    localparam string VEC_FILE = "sim/bpu_vectors.txt";

    logic                   clk = 1'b0;
    logic                   rst_n;
    bpu_pkg::fetch_req_t    fetch;
    bpu_pkg::prediction_t   prediction;
    logic                   resolve_req;
    bpu_pkg::resolve_t      resolve;
    logic                   resolve_ack;
    bpu_pkg::redirect_t     redirect;

    int                     cycle_count = 0;
    int                     timeout_limit = 0;
    int                     vec_count = 0;
    int                     file_errors = 0;

    // reference btb: pc of the last taken branch written to each slot
    logic [`BPU_PC_W-1:0]           btb_pc [`BPU_BTB_ENTRIES];
    logic [`BPU_BTB_ENTRIES-1:0]    btb_used = '0;

    bpu_top i_dut (.clk, .rst_n, .fetch, .prediction, .resolve_req, .resolve,
                   .resolve_ack, .redirect);

    bpu_checker i_checker (.clk, .prediction, .resolve_ack, .redirect);

    always #4 clk = ~clk;                       // 8 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (timeout_limit != 0);
        wait (cycle_count >= timeout_limit);
        $display("timeout: run did not finish within %0d cycles", timeout_limit);
        $display("Finished with errors");
        $finish;
    end

    task automatic count_vectors(input int fd);
        logic [7:0]         tok;
        logic [8*128-1:0]   rest;
        int                 rc;
        while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", tok);
            if (rc == 1) begin
                if (tok == "L" || tok == "R") begin
                    vec_count++;
                end
                rc = $fgets(rest, fd);          // skip the rest of the line
            end
        end
    endtask

    task automatic run_lookup(input string name, input logic [`BPU_PC_W-1:0] pc,
                              input logic exp_taken, input logic [`BPU_PC_W-1:0] exp_next_pc);
        logic [`BPU_BTB_IDX_W-1:0]  slot;
        logic                       exp_hit;
        slot    = pc[`BPU_BTB_IDX_W+1:2];
        exp_hit = btb_used[slot] && (btb_pc[slot][`BPU_PC_W-1:2] == pc[`BPU_PC_W-1:2]);
        fetch = '{valid: 1'b1, pc: pc};
        i_checker.expect_lookup(name, exp_taken, exp_hit, exp_next_pc);
        @(negedge clk);
    endtask

    task automatic run_resolve(input string name, input bpu_pkg::resolve_t br, input int hold,
                               input logic exp_misp, input logic [`BPU_PC_W-1:0] exp_pc);
        logic [`BPU_BTB_IDX_W-1:0]  slot;
        slot        = br.pc[`BPU_BTB_IDX_W+1:2];
        fetch.valid = 1'b0;
        resolve     = br;
        resolve_req = 1'b1;
        i_checker.expect_resolve(name, exp_misp, exp_pc);
        @(negedge clk);
        while (!resolve_ack) begin
            @(negedge clk);
        end
        repeat (hold) @(negedge clk);           // stalled requester
        resolve_req = 1'b0;
        @(negedge clk);
        while (resolve_ack) begin
            @(negedge clk);
        end
        if (br.taken) begin                     // only taken branches allocate
            btb_pc[slot]   = br.pc;
            btb_used[slot] = 1'b1;
        end
    endtask

    task automatic run_vectors(input int fd);
        logic [7:0]             tok;
        logic [8*24-1:0]        name;
        logic [8*128-1:0]       rest;
        logic [`BPU_PC_W-1:0]   pc;
        logic [`BPU_PC_W-1:0]   target;
        logic [`BPU_PC_W-1:0]   pred_pc;
        logic [`BPU_PC_W-1:0]   exp_pc;
        logic                   taken;
        logic                   pred_taken;
        logic                   exp_bit;
        bpu_pkg::resolve_t      br;
        int                     hold;
        int                     rc;
        while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", tok);
            if (rc == 1) begin
                if (tok == "L") begin
                    rc = $fscanf(fd, "%s %h %h %h", name, pc, exp_bit, exp_pc);
                    if (rc == 4) begin
                        run_lookup(string'(name), pc, exp_bit, exp_pc);
                    end else begin
                        $display("malformed lookup line in %s", VEC_FILE);
                        file_errors++;
                    end
                end else if (tok == "R") begin
                    rc = $fscanf(fd, "%s %h %h %h %h %h %d %h %h", name, pc, taken, target,
                                 pred_taken, pred_pc, hold, exp_bit, exp_pc);
                    if (rc == 9) begin
                        br = '{pc: pc, taken: taken, target: target,
                               pred_taken: pred_taken, pred_next_pc: pred_pc};
                        run_resolve(string'(name), br, hold, exp_bit, exp_pc);
                    end else begin
                        $display("malformed resolve line in %s", VEC_FILE);
                        file_errors++;
                    end
                end else if (tok == "#") begin
                    rc = $fgets(rest, fd);      // column description
                end else begin
                    $display("unknown record type in %s", VEC_FILE);
                    file_errors++;
                    rc = $fgets(rest, fd);
                end
            end
        end
    endtask

    initial begin
        int fd;
        int total_errors;
        rst_n       = 1'b0;
        fetch       = '0;
        resolve_req = 1'b0;
        resolve     = '0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s for reading", VEC_FILE);
            file_errors++;
        end else begin
            count_vectors(fd);
            $fclose(fd);
            timeout_limit = vec_count * 10 + 50;
            repeat (4) @(posedge clk);          // four clock cycles in reset
            @(negedge clk);
            rst_n = 1'b1;
            @(negedge clk);
            fd = $fopen(VEC_FILE, "r");
            run_vectors(fd);
            $fclose(fd);
            repeat (2) @(negedge clk);          // let the last lookup be compared
            if (i_checker.test_count != vec_count) begin
                $display("only %0d of %0d vector tests completed",
                         i_checker.test_count, vec_count);
                file_errors++;
            end
        end
        total_errors = i_checker.error_count + file_errors;
        $display("tests run: %0d, errors: %0d", i_checker.test_count, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bpu_top.f
+incdir+logic
logic/bpu_pkg.sv
logic/bht.sv
logic/btb.sv
logic/branch_resolve.sv
logic/bpu_top.sv
sim/bpu_checker.sv
sim/bpu_tb.sv

//--- Makefile
# Verilator build and run of the branch prediction unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = bpu_tb
FILELIST  = bpu_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/bpu_vectors.txt
# L name pc exp_taken exp_next_pc
# R name pc taken target pred_taken pred_next_pc hold exp_mispredict exp_correct_pc
L reset_a 00001104 0 00001108
L reset_b 00002208 0 0000220c
L reset_c 0000fffc 0 00010000
R a_taken_1 00001104 1 00001800 0 00001108 0 1 00001800
L a_after_1 00001104 0 00001108
R a_taken_2 00001104 1 00001800 0 00001108 0 1 00001800
L a_after_2 00001104 1 00001800
R b_taken_1 00002208 1 00002400 0 0000220c 0 1 00002400
R b_taken_2 00002208 1 00002400 0 0000220c 0 1 00002400
L b_after_2 00002208 1 00002400
R b_taken_3 00002208 1 00002400 1 00002400 0 0 00002400
R b_not_taken_1 00002208 0 00002400 1 00002400 0 1 0000220c
L b_after_nt_1 00002208 1 00002400
R b_not_taken_2 00002208 0 00002400 1 00002400 0 1 0000220c
L b_after_nt_2 00002208 0 0000220c
R c_taken_1 0000330c 1 00003500 0 00003310 0 1 00003500
R c_taken_2 0000330c 1 00003500 0 00003310 0 1 00003500
L c_after_2 0000330c 1 00003500
L d_alias_miss 0001330c 0 00013310
R d_not_taken 0001330c 0 00013500 0 00013310 0 0 00013310
L c_shared_cnt 0000330c 0 00003310
R d_taken 0001330c 1 00013600 0 00013310 0 1 00013600
L d_after_taken 0001330c 1 00013600
L c_evicted 0000330c 0 00003310
R a_new_target 00001104 1 00001a00 1 00001800 0 1 00001a00
L a_after_new 00001104 1 00001a00
R a_correct 00001104 1 00001a00 1 00001a00 0 0 00001a00
R f_correct_nt 00004014 0 00004100 0 00004018 0 0 00004018
L f_after_nt 00004014 0 00004018
R e_held_1 00005510 1 00005a00 0 00005514 5 1 00005a00
L e_after_held_1 00005510 0 00005514
R e_held_2 00005510 1 00005a00 0 00005514 4 1 00005a00
L e_after_held_2 00005510 1 00005a00
